// File: source/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [5:0] opcode_t;                   // Instruction bits 31:26
    typedef logic [5:0] funct_t;                    // Instruction bits 5:0

    //////////////////////////////////////////////////////////////////////
    // Opcode field values
    //////////////////////////////////////////////////////////////////////

    localparam opcode_t OpRType = 6'h00;            // Funct picks the operation
    localparam opcode_t OpJ     = 6'h02;
    localparam opcode_t OpJal   = 6'h03;
    localparam opcode_t OpBeq   = 6'h04;
    localparam opcode_t OpBne   = 6'h05;
    localparam opcode_t OpBle   = 6'h06;
    localparam opcode_t OpBgt   = 6'h07;
    localparam opcode_t OpAddi  = 6'h08;
    localparam opcode_t OpAddiu = 6'h09;
    localparam opcode_t OpSlti  = 6'h0a;
    localparam opcode_t OpLui   = 6'h0f;
    localparam opcode_t OpLw    = 6'h23;
    localparam opcode_t OpSw    = 6'h2b;

    // R-type funct values
    localparam funct_t FnJr  = 6'h08;
    localparam funct_t FnAdd = 6'h20;
    localparam funct_t FnSub = 6'h22;
    localparam funct_t FnAnd = 6'h24;
    localparam funct_t FnOr  = 6'h25;
    localparam funct_t FnSlt = 6'h2a;

    //////////////////////////////////////////////////////////////////////
    // One class per supported instruction
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        ClsAdd,
        ClsSub,
        ClsAnd,
        ClsOr,
        ClsSlt,
        ClsJr,
        ClsAddi,
        ClsAddiu,
        ClsSlti,
        ClsLui,
        ClsBeq,
        ClsBne,
        ClsBle,
        ClsBgt,
        ClsLw,
        ClsSw,
        ClsJ,
        ClsJal,
        ClsInvalid                                  // Anything not listed above
    } instrClass_t;

endpackage

`default_nettype wire

// File: source/controlPkg.sv
`default_nettype none

package controlPkg;

    //////////////////////////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        StInit,                                     // Stack pointer load after reset
        StFetch1,
        StFetch2,
        StDecode,
        StAluExec,
        StImmExec,
        StWriteRd,
        StWriteRt,
        StJrExec,
        StSavePc,
        StBranchTarget,
        StCompare,
        StCondPc,
        StAddrCalc,
        StReadMem,                                  // Held for the memory latency
        StLoadWrite,
        StStore,
        StJump,
        StJal,
        StInvalidOp,
        StOverflow,
        StException
    } state_t;

    //////////////////////////////////////////////////////////////////////
    // Datapath control encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        AluLoad     = 5'b00000,                     // Pass A through
        AluAddOvf   = 5'b00001,                     // Add, flags overflow
        AluSub      = 5'b00010,
        AluAnd      = 5'b00011,
        AluOr       = 5'b01000,
        AluCmp      = 5'b00111,                     // Set on less than
        AluAddNoOvf = 5'b01011,
        AluLui      = 5'b10010,                     // Immediate to upper half
        AluEq       = 5'b01111,
        AluNe       = 5'b01110,
        AluLe       = 5'b10000,
        AluGt       = 5'b10001
    } aluOp_t;

    typedef enum logic [1:0] {
        SrcBReg       = 2'd0,
        SrcBFour      = 2'd1,
        SrcBImm       = 2'd2,
        SrcBBranchOff = 2'd3                        // Sign extended and shifted by 2
    } aluSrcB_t;

    typedef enum logic [1:0] {
        DestRt = 2'd0,
        DestRd = 2'd1,
        DestRa = 2'd2,
        DestSp = 2'd3
    } regDest_t;

    typedef enum logic [2:0] {
        WbAlu       = 3'd0,
        WbMem       = 3'd1,
        WbStackInit = 3'd2,                         // Initial stack pointer constant
        WbExcVector = 3'd3,
        WbPc        = 3'd4
    } memToReg_t;

    typedef enum logic [1:0] {
        PcJumpTarget = 2'd0,
        PcAluOut     = 2'd1,                        // Registered ALU result
        PcAluResult  = 2'd2,                        // Live ALU result
        PcExcVector  = 2'd3
    } pcSource_t;

    typedef enum logic [1:0] {
        ExcNone     = 2'd0,
        ExcInvalid  = 2'd1,
        ExcOverflow = 2'd2
    } excCause_t;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire isaPkg::opcode_t    opcode,
    input  wire isaPkg::funct_t     funct,
    output isaPkg::instrClass_t     instrClass
);

    import isaPkg::*;

    always_comb
    begin
        case (opcode)
            OpRType:
            begin
                case (funct)                        // Funct only matters for R-type
                    FnAdd:   instrClass = ClsAdd;
                    FnSub:   instrClass = ClsSub;
                    FnAnd:   instrClass = ClsAnd;
                    FnOr:    instrClass = ClsOr;
                    FnSlt:   instrClass = ClsSlt;
                    FnJr:    instrClass = ClsJr;
                    default: instrClass = ClsInvalid;
                endcase
            end

            // Immediate arithmetic
            OpAddi:  instrClass = ClsAddi;
            OpAddiu: instrClass = ClsAddiu;
            OpSlti:  instrClass = ClsSlti;
            OpLui:   instrClass = ClsLui;

            // Branches
            OpBeq:   instrClass = ClsBeq;
            OpBne:   instrClass = ClsBne;
            OpBle:   instrClass = ClsBle;
            OpBgt:   instrClass = ClsBgt;

            // Word memory access
            OpLw:    instrClass = ClsLw;
            OpSw:    instrClass = ClsSw;

            OpJ:     instrClass = ClsJ;
            OpJal:   instrClass = ClsJal;
            default: instrClass = ClsInvalid;       // Raises the invalid opcode exception
        endcase
    end

endmodule

`default_nettype wire

// File: source/waitTimer.sv
`timescale 1ns/1ps
`default_nettype none

module waitTimer #(
    parameter int WaitCycles = 2                    // At least 1
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic waitHold,
    output logic      waitDone
);

    localparam int CountWidth = (WaitCycles > 1) ? $clog2(WaitCycles) : 1;
    localparam logic [CountWidth-1:0] LastCount = CountWidth'(WaitCycles - 1);

    logic [CountWidth-1:0] count;

    // Last cycle of the wait
    assign waitDone = waitHold && (count == LastCount);

    always_ff @(posedge clk)
    begin
        if (reset || !waitHold || waitDone)
        begin
            count <= '0;                            // Idle or wait finished
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire isaPkg::instrClass_t instrClass,
    input  wire logic                overflow,
    input  wire logic                waitDone,
    output logic                     waitHold,
    output controlPkg::state_t       state
);

    import isaPkg::*;
    import controlPkg::*;

    state_t stateNext;

    // Startup and memory read are timed by the wait timer
    assign waitHold = (state == StInit) || (state == StReadMem);

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        stateNext = state;
        case (state)
            StInit:
            begin
                if (waitDone)
                begin
                    stateNext = StFetch1;
                end
            end
            StFetch1: stateNext = StFetch2;
            StFetch2: stateNext = StDecode;

            StDecode:
            begin
                case (instrClass)
                    ClsAdd, ClsSub, ClsAnd, ClsOr, ClsSlt:
                        stateNext = StAluExec;
                    ClsAddi, ClsAddiu, ClsSlti, ClsLui:
                        stateNext = StImmExec;
                    ClsBeq, ClsBne, ClsBle, ClsBgt:
                        stateNext = StBranchTarget;
                    ClsLw, ClsSw:
                        stateNext = StAddrCalc;
                    ClsJr:   stateNext = StJrExec;
                    ClsJ:    stateNext = StJump;
                    ClsJal:  stateNext = StJal;
                    default: stateNext = StInvalidOp;
                endcase
            end

            StAluExec:      stateNext = StWriteRd;
            StImmExec:      stateNext = StWriteRt;
            StJrExec:       stateNext = StSavePc;
            StBranchTarget: stateNext = StCompare;
            StCompare:      stateNext = StCondPc;

            StAddrCalc:
            begin
                if (instrClass == ClsLw)
                begin
                    stateNext = StReadMem;
                end
                else
                begin
                    stateNext = StStore;
                end
            end
            StReadMem:
            begin
                if (waitDone)
                begin
                    stateNext = StLoadWrite;        // Read data valid now
                end
            end

            StInvalidOp, StOverflow: stateNext = StException;

            // Last state of every instruction
            default: stateNext = StFetch1;
        endcase

        // Overflow wins over any other transition
        if (overflow && (state != StInit) && (state != StOverflow))
        begin
            stateNext = StOverflow;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= StInit;
        end
        else
        begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

// File: source/controlOutputs.sv
`timescale 1ns/1ps
`default_nettype none

module controlOutputs (
    input  wire controlPkg::state_t   state,
    input  wire isaPkg::instrClass_t  instrClass,
    output logic                      pcWrite,
    output logic                      pcWriteCond,
    output logic                      iOrD,
    output logic                      irWrite,
    output logic                      memWrite,
    output logic                      regWrite,
    output logic                      epcWrite,
    output logic                      aluSrcA,
    output controlPkg::aluSrcB_t      aluSrcB,
    output controlPkg::aluOp_t        aluOp,
    output controlPkg::regDest_t      regDest,
    output controlPkg::memToReg_t     memToReg,
    output controlPkg::pcSource_t     pcSource,
    output controlPkg::excCause_t     excCause
);

    import isaPkg::*;
    import controlPkg::*;

    aluOp_t regOp;                                  // R-type execute
    aluOp_t immOp;                                  // I-type execute
    aluOp_t cmpOp;                                  // Branch compare

    always_comb
    begin
        case (instrClass)
            ClsSub:  regOp = AluSub;
            ClsAnd:  regOp = AluAnd;
            ClsOr:   regOp = AluOr;
            ClsSlt:  regOp = AluCmp;
            default: regOp = AluAddOvf;
        endcase
        case (instrClass)
            ClsAddiu: immOp = AluAddNoOvf;
            ClsSlti:  immOp = AluCmp;
            ClsLui:   immOp = AluLui;
            default:  immOp = AluAddOvf;
        endcase
        case (instrClass)
            ClsBne:  cmpOp = AluNe;
            ClsBle:  cmpOp = AluLe;
            ClsBgt:  cmpOp = AluGt;
            default: cmpOp = AluEq;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Per-state control values
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        iOrD        = 1'b0;                         // PC addresses memory
        irWrite     = 1'b0;
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        epcWrite    = 1'b0;
        aluSrcA     = 1'b0;                         // PC as operand A
        aluSrcB     = SrcBReg;
        aluOp       = AluLoad;
        regDest     = DestRt;
        memToReg    = WbAlu;
        pcSource    = PcAluResult;
        excCause    = ExcNone;

        case (state)
            StInit:
            begin
                regWrite = 1'b1;
                regDest  = DestSp;
                memToReg = WbStackInit;
            end
            StFetch2:
            begin
                irWrite  = 1'b1;
                pcWrite  = 1'b1;                    // PC + 4
                aluOp    = AluAddOvf;
                aluSrcB  = SrcBFour;
            end

            // Register and immediate arithmetic
            StAluExec:
            begin
                aluSrcA = 1'b1;
                aluOp   = regOp;
            end
            StImmExec:
            begin
                aluSrcA = 1'b1;
                aluSrcB = SrcBImm;
                aluOp   = immOp;
            end
            StWriteRd:
            begin
                regWrite = 1'b1;
                regDest  = DestRd;
            end
            StWriteRt: regWrite = 1'b1;

            StJrExec:
            begin
                aluSrcA = 1'b1;                     // Rs passes through
                aluOp   = AluLoad;
            end
            StSavePc: pcWrite = 1'b1;

            // Branches
            StBranchTarget:
            begin
                aluSrcB = SrcBBranchOff;
                aluOp   = AluAddNoOvf;
            end
            StCompare:
            begin
                aluSrcA = 1'b1;
                aluOp   = cmpOp;
            end
            StCondPc:
            begin
                pcWriteCond = 1'b1;
                pcSource    = PcAluOut;             // Target from StBranchTarget
            end

            // Memory access
            StAddrCalc:
            begin
                aluSrcA = 1'b1;
                aluSrcB = SrcBImm;
                aluOp   = AluAddNoOvf;
            end
            StReadMem: iOrD = 1'b1;
            StLoadWrite:
            begin
                regWrite = 1'b1;
                memToReg = WbMem;
            end
            StStore:
            begin
                iOrD     = 1'b1;
                memWrite = 1'b1;
            end

            StJump:
            begin
                pcWrite  = 1'b1;
                pcSource = PcJumpTarget;
            end
            StJal:
            begin
                pcWrite  = 1'b1;
                pcSource = PcJumpTarget;
                regWrite = 1'b1;                    // Return address to ra
                regDest  = DestRa;
                memToReg = WbPc;
            end

            // Exceptions
            StInvalidOp:
            begin
                epcWrite = 1'b1;
                excCause = ExcInvalid;
            end
            StOverflow:
            begin
                epcWrite = 1'b1;
                excCause = ExcOverflow;
            end
            StException:
            begin
                pcWrite  = 1'b1;
                pcSource = PcExcVector;
                regWrite = 1'b1;
                regDest  = DestRa;
                memToReg = WbExcVector;
            end
            default: ;                              // Fetch1 and decode keep defaults
        endcase
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
    parameter int MemWaitCycles = 2                 // Memory read latency
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire isaPkg::opcode_t    opcode,
    input  wire isaPkg::funct_t     funct,
    input  wire logic               overflow,
    output logic                    pcWrite,
    output logic                    pcWriteCond,
    output logic                    iOrD,
    output logic                    irWrite,
    output logic                    memWrite,
    output logic                    regWrite,
    output logic                    epcWrite,
    output logic                    aluSrcA,
    output controlPkg::aluSrcB_t    aluSrcB,
    output controlPkg::aluOp_t      aluOp,
    output controlPkg::regDest_t    regDest,
    output controlPkg::memToReg_t   memToReg,
    output controlPkg::pcSource_t   pcSource,
    output controlPkg::excCause_t   excCause
);

    import isaPkg::*;
    import controlPkg::*;

    instrClass_t instrClass;
    state_t      state;
    logic        waitHold;
    logic        waitDone;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    waitTimer #(
        .WaitCycles (MemWaitCycles)
    ) timer (
        .clk      (clk),
        .reset    (reset),
        .waitHold (waitHold),
        .waitDone (waitDone)
    );

    controlSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .waitDone   (waitDone),
        .waitHold   (waitHold),
        .state      (state)
    );

    controlOutputs outputs (
        .state       (state),
        .instrClass  (instrClass),                 // Picks the ALU operation
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iOrD        (iOrD),
        .irWrite     (irWrite),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .epcWrite    (epcWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .regDest     (regDest),
        .memToReg    (memToReg),
        .pcSource    (pcSource),
        .excCause    (excCause)
    );

endmodule

`default_nettype wire

// File: testbench/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    import isaPkg::*;
    import controlPkg::*;

    localparam int MemWait    = 2;
    localparam int CycleLimit = 2000;               // Directed sequence needs under 200

    // Enable bits in the order {pcWrite, pcWriteCond, irWrite, memWrite, regWrite, epcWrite}
    localparam logic [5:0] EnNone   = 6'b000000;
    localparam logic [5:0] EnPc     = 6'b100000;
    localparam logic [5:0] EnPcCond = 6'b010000;
    localparam logic [5:0] EnIr     = 6'b001000;
    localparam logic [5:0] EnMem    = 6'b000100;
    localparam logic [5:0] EnReg    = 6'b000010;
    localparam logic [5:0] EnEpc    = 6'b000001;

    logic      clk;
    logic      reset;
    opcode_t   opcode;
    funct_t    funct;
    logic      overflow;
    logic      pcWrite;
    logic      pcWriteCond;
    logic      iOrD;
    logic      irWrite;
    logic      memWrite;
    logic      regWrite;
    logic      epcWrite;
    logic      aluSrcA;
    aluSrcB_t  aluSrcB;
    aluOp_t    aluOp;
    regDest_t  regDest;
    memToReg_t memToReg;
    pcSource_t pcSource;
    excCause_t excCause;

    int     errorCount;
    int     checkCount;
    int     instrCycle;                             // Cycle 1 is the first fetch state
    int     cycleCount;
    integer seed;
    string  testName;

    controlUnit #(
        .MemWaitCycles (MemWait)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .overflow    (overflow),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iOrD        (iOrD),
        .irWrite     (irWrite),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .epcWrite    (epcWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .regDest     (regDest),
        .memToReg    (memToReg),
        .pcSource    (pcSource),
        .excCause    (excCause)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Check helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compareValue(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %s = 0x%h, expected 0x%h (%s, cycle %0d)",
                     name, actual, expected, testName, instrCycle);
        end
    endtask

    task automatic checkEnables(input logic [5:0] expected);
        compareValue("enables", {pcWrite, pcWriteCond, irWrite, memWrite, regWrite, epcWrite},
                     expected);
    endtask

    // Outputs settle long before the falling edge
    task automatic nextCycle();
        @(negedge clk);
        instrCycle++;
    endtask

    task automatic checkInit();
        checkEnables(EnReg);
        compareValue("regDest", regDest, DestSp);
        compareValue("memToReg", memToReg, WbStackInit);
    endtask

    task automatic checkExceptionEntry();
        checkEnables(EnPc | EnReg);
        compareValue("pcSource", pcSource, PcExcVector);
        compareValue("regDest", regDest, DestRa);
        compareValue("memToReg", memToReg, WbExcVector);
    endtask

    function automatic logic isKnownOpcode(input opcode_t op);
        case (op)
            OpRType, OpAddi, OpAddiu, OpSlti, OpLui, OpBeq, OpBne,
            OpBle, OpBgt, OpLw, OpSw, OpJ, OpJal:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // Drives the instruction, then checks fetch and decode (cycles 1 to 3)
    task automatic startInstr(input string name, input opcode_t op, input funct_t fn);
        testName   = name;
        opcode     = op;
        funct      = fn;
        instrCycle = 0;
        nextCycle();
        checkEnables(EnNone);
        nextCycle();
        checkEnables(EnPc | EnIr);
        compareValue("aluOp", aluOp, AluAddOvf);
        compareValue("aluSrcA", aluSrcA, 1'b0);     // PC + 4
        compareValue("aluSrcB", aluSrcB, SrcBFour);
        nextCycle();
        checkEnables(EnNone);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic testStartup();
        testName   = "startup";
        instrCycle = 0;
        repeat (5)
        begin
            nextCycle();
            checkInit();
        end
        reset = 1'b0;
        repeat (MemWait - 1)                        // Reset falls in the first wait cycle
        begin
            nextCycle();
            checkInit();
        end
    endtask

    task automatic testArith(input string name, input opcode_t op, input funct_t fn,
                             input logic rType, input aluOp_t expOp);
        startInstr(name, op, fn);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluOp", aluOp, expOp);
        compareValue("aluSrcA", aluSrcA, 1'b1);     // Register rs
        compareValue("aluSrcB", aluSrcB, rType ? SrcBReg : SrcBImm);
        nextCycle();
        checkEnables(EnReg);
        compareValue("regDest", regDest, rType ? DestRd : DestRt);
        compareValue("memToReg", memToReg, WbAlu);
    endtask

    task automatic testBranch(input string name, input opcode_t op, input aluOp_t expOp);
        startInstr(name, op, 6'h00);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluSrcA", aluSrcA, 1'b0);     // PC plus offset
        compareValue("aluSrcB", aluSrcB, SrcBBranchOff);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluOp", aluOp, expOp);
        compareValue("aluSrcA", aluSrcA, 1'b1);
        nextCycle();
        checkEnables(EnPcCond);                     // pcWrite must stay low
        compareValue("pcSource", pcSource, PcAluOut);
    endtask

    task automatic testLoad();
        startInstr("lw", OpLw, 6'h00);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluSrcA", aluSrcA, 1'b1);     // Base register plus offset
        compareValue("aluSrcB", aluSrcB, SrcBImm);
        repeat (MemWait)
        begin
            nextCycle();
            checkEnables(EnNone);
            compareValue("iOrD", iOrD, 1'b1);
        end
        nextCycle();
        checkEnables(EnReg);
        compareValue("memToReg", memToReg, WbMem);
        compareValue("regDest", regDest, DestRt);
    endtask

    task automatic testStore();
        startInstr("sw", OpSw, 6'h00);
        nextCycle();
        checkEnables(EnNone);
        nextCycle();
        checkEnables(EnMem);
        compareValue("iOrD", iOrD, 1'b1);
    endtask

    task automatic testJump(input string name, input opcode_t op, input logic link);
        startInstr(name, op, 6'h00);
        nextCycle();
        compareValue("pcSource", pcSource, PcJumpTarget);
        if (link)
        begin
            checkEnables(EnPc | EnReg);
            compareValue("regDest", regDest, DestRa);
            compareValue("memToReg", memToReg, WbPc);
        end
        else
        begin
            checkEnables(EnPc);
        end
    endtask

    task automatic testJr();
        startInstr("jr", OpRType, FnJr);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluSrcA", aluSrcA, 1'b1);     // Rs to the ALU
        nextCycle();
        checkEnables(EnPc);
        compareValue("pcSource", pcSource, PcAluResult);
    endtask

    task automatic testInvalid(input string name, input opcode_t op, input funct_t fn);
        startInstr(name, op, fn);
        nextCycle();
        checkEnables(EnEpc);
        compareValue("excCause", excCause, ExcInvalid);
        nextCycle();
        checkExceptionEntry();
    endtask

    task automatic testRandomInvalid(input int draws);
        integer  randomValue;
        opcode_t candidate;
        repeat (draws)
        begin
            candidate = OpRType;
            while (isKnownOpcode(candidate))
            begin
                randomValue = $random(seed);
                candidate   = randomValue[5:0];
            end
            testInvalid($sformatf("random opcode 0x%h", candidate), candidate, 6'h00);
        end
    endtask

    task automatic testOverflow();
        startInstr("add overflow", OpRType, FnAdd);
        nextCycle();
        checkEnables(EnNone);
        compareValue("aluOp", aluOp, AluAddOvf);
        overflow = 1'b1;                            // Seen at the end of execute
        nextCycle();
        checkEnables(EnEpc);
        compareValue("excCause", excCause, ExcOverflow);
        overflow = 1'b0;
        nextCycle();
        checkExceptionEntry();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset      = 1'b1;
        opcode     = OpRType;
        funct      = FnAdd;
        overflow   = 1'b0;
        errorCount = 0;
        checkCount = 0;
        instrCycle = 0;
        seed       = 32'h6ad8;
        testName   = "init";

        testStartup();
        testArith("add", OpRType, FnAdd, 1'b1, AluAddOvf);
        testArith("sub", OpRType, FnSub, 1'b1, AluSub);
        testArith("and", OpRType, FnAnd, 1'b1, AluAnd);
        testArith("or", OpRType, FnOr, 1'b1, AluOr);
        testArith("slt", OpRType, FnSlt, 1'b1, AluCmp);
        testArith("addi", OpAddi, 6'h00, 1'b0, AluAddOvf);
        testArith("addiu", OpAddiu, 6'h00, 1'b0, AluAddNoOvf);
        testArith("slti", OpSlti, 6'h00, 1'b0, AluCmp);
        testArith("lui", OpLui, 6'h00, 1'b0, AluLui);
        testBranch("beq", OpBeq, AluEq);
        testBranch("bne", OpBne, AluNe);
        testBranch("ble", OpBle, AluLe);
        testBranch("bgt", OpBgt, AluGt);
        testLoad();
        testStore();
        testJump("j", OpJ, 1'b0);
        testJump("jal", OpJal, 1'b1);
        testJr();
        testInvalid("opcode 0x3f", 6'h3f, 6'h00);
        testInvalid("R-type funct 0x3f", OpRType, 6'h3f);
        testRandomInvalid(6);
        testOverflow();
        testArith("add after overflow", OpRType, FnAdd, 1'b1, AluAddOvf);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < CycleLimit)
        begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", CycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/isaPkg.sv
source/controlPkg.sv
source/instrDecoder.sv
source/waitTimer.sv
source/controlSequencer.sv
source/controlOutputs.sv
source/controlUnit.sv
testbench/controlUnitTb.sv
